/* rtl/mmio_pkg.sv */
package mmio_pkg;

   // ==================================================
   // Widths with a meaning
   // ==================================================
   typedef logic [31:0] mmio_addr_t;   // Host address
   typedef logic [63:0] mmio_data_t;   // Global register / host data
   typedef logic [31:0] lcl_data_t;    // Action data and address word
   typedef logic [13:0] area_base_t;   // Register group, addr[21:8]
   typedef logic [7:0]  area_offset_t; // Offset in group, addr[7:0]
   typedef logic [3:0]  fir_t;         // Data bridge fault flags

   // ==================================================
   // Address map
   // ==================================================
   localparam int ACTION_ACCESS_BIT = 31; // 1 = action area, 4B access
   localparam int LANE_BIT          = 2;  // Upper/lower 32b half
   localparam int BASE_LSB          = 8;  // Group base starts here

   // Register groups
   localparam area_base_t BASE_INFRA = 14'h0000;
   localparam area_base_t BASE_DEBUG = 14'h01A0;
   localparam area_base_t BASE_FIR   = 14'h01C0;

   // Infrastructure group
   localparam area_offset_t OFS_IMP_VERSION = 8'h00; // RO
   localparam area_offset_t OFS_BUILD_DATE  = 8'h08; // RO
   localparam area_offset_t OFS_COMMAND     = 8'h10; // WO
   localparam area_offset_t OFS_STATUS      = 8'h18; // RO
   localparam area_offset_t OFS_CAPABILITY  = 8'h30; // RO
   localparam area_offset_t OFS_NAME1       = 8'h40; // RO, action name words
   localparam area_offset_t OFS_NAME2       = 8'h48;
   localparam area_offset_t OFS_NAME3       = 8'h50;
   localparam area_offset_t OFS_NAME4       = 8'h58;

   // Debug group
   localparam area_offset_t OFS_DBG_CLEAR   = 8'h00; // WO, self clearing
   localparam area_offset_t OFS_AXI_CMD     = 8'h40; // RO
   localparam area_offset_t OFS_AXI_RSP     = 8'h48; // RO
   localparam area_offset_t OFS_BUF_CNT     = 8'h50; // RO

   // Fault group
   localparam area_offset_t OFS_FIR_BRIDGE  = 8'h00; // RO

   localparam int SOFT_RESET_CYCLES = 16; // Action soft reset length

   // ==================================================
   // Bundles
   // ==================================================
   typedef struct packed {
      fir_t       fir;          // [195:192]
      mmio_data_t axi_cnt_cmd;  // [191:128]
      mmio_data_t axi_cnt_rsp;  // [127:64]
      mmio_data_t buf_cnt;      // [63:0]
   } bridge_debug_t;

   typedef struct packed {
      logic fatal_error;
      logic axi_busy;
      logic tlx_busy;    // No transport side here, always 0
      logic bridge_idle;
   } status_t;

   typedef struct packed {
      logic       wr;
      logic       rd;
      mmio_addr_t addr;
      mmio_data_t din;
   } mmio_req_t;

   typedef struct packed {
      logic       valid;
      logic       error;  // Decode error or bad action response
      mmio_data_t data;
   } mmio_rsp_t;

endpackage

/* rtl/mmio_host_port.sv */
module mmio_host_port
   import mmio_pkg::*;
(
   input  logic       clk,
   input  logic       resetn,
   input  logic       mmio_wr,
   input  logic       mmio_rd,
   input  logic       mmio_dw,
   input  mmio_addr_t mmio_addr,
   input  mmio_data_t mmio_din,
   output mmio_data_t mmio_dout,
   output logic       mmio_done,
   output logic       mmio_failed,
   output mmio_req_t  global_req,
   output mmio_req_t  action_req,
   input  mmio_rsp_t  global_rsp,
   input  mmio_rsp_t  action_rsp
);

   logic      req_valid;
   logic      area_action;  // Bit 31 set
   logic      width_ok;     // 4B for action, 8B for global
   logic      pend_rd;      // Outstanding request is a read
   mmio_rsp_t rsp;

   assign req_valid   = mmio_wr | mmio_rd;
   assign area_action = mmio_addr[ACTION_ACCESS_BIT];
   assign width_ok    = area_action ? ~mmio_dw : mmio_dw;

   // Same request to both sides, strobes only on the addressed one
   always_comb
   begin
      global_req    = '{wr: mmio_wr, rd: mmio_rd, addr: mmio_addr, din: mmio_din};
      action_req    = global_req;
      global_req.wr = mmio_wr & width_ok & ~area_action;
      global_req.rd = mmio_rd & width_ok & ~area_action;
      action_req.wr = mmio_wr & width_ok & area_action;
      action_req.rd = mmio_rd & width_ok & area_action;
   end

   // Only one request in flight, so at most one side answers
   assign rsp = global_rsp.valid ? global_rsp : action_rsp;

   // ==================================================
   // Completion to host
   // ==================================================
   always_ff @(posedge clk or negedge resetn)
   begin
      if (!resetn)
      begin
         mmio_done   <= 1'b0;
         mmio_failed <= 1'b0;
         pend_rd     <= 1'b0;
         mmio_dout   <= '0;
      end
      else
      begin
         mmio_done   <= rsp.valid & ~rsp.error;
         mmio_failed <= (req_valid & ~width_ok)  // Wrong access width
                      | (rsp.valid & rsp.error);  // Decode error or bad rsp
         if (req_valid)
            pend_rd <= mmio_rd;
         if (rsp.valid && !rsp.error && pend_rd)
            mmio_dout <= rsp.data;  // Held until next good read
      end
   end

endmodule

/* rtl/global_reg_file.sv */
module global_reg_file
   import mmio_pkg::*;
#(
   parameter mmio_data_t  IMP_VERSION      = 64'h1000_0000_0000_0000,
   parameter mmio_data_t  BUILD_DATE       = 64'h0000_2000_0101_0800,
   parameter mmio_data_t  ACTION_NAME_STR1 = 64'h7465_7374_2020_2020,
   parameter mmio_data_t  ACTION_NAME_STR2 = 64'h2020_2020_2020_2020,
   parameter mmio_data_t  ACTION_NAME_STR3 = 64'h2020_2020_2020_2020,
   parameter mmio_data_t  ACTION_NAME_STR4 = 64'h2020_2020_2020_2020,
   parameter logic [7:0]  ENGINE_NUMBER    = 8'h01,
   parameter logic [47:0] OTHER_CAPABILITY = 48'h0,
   parameter logic [7:0]  CARD_TYPE        = 8'h31
)
(
   input  logic          clk,
   input  logic          resetn,
   input  mmio_req_t     global_req,
   input  bridge_debug_t debug,
   input  status_t       status,
   output mmio_rsp_t     global_rsp,
   output logic          command_pulse,
   output logic          debug_info_clear
);

   area_base_t   base;
   area_offset_t offset;
   mmio_data_t   rd_data;
   logic         rd_hit;     // Readable register addressed
   logic         cmd_hit;    // Command register addressed
   logic         clr_hit;    // Debug clear addressed
   logic         rsp_valid;
   logic         rsp_error;
   mmio_data_t   rsp_data;

   assign base   = global_req.addr[BASE_LSB +: $bits(area_base_t)];
   assign offset = global_req.addr[$bits(area_offset_t)-1:0];

   // ==================================================
   // Address decode
   // ==================================================
   always_comb
   begin
      rd_data = '0;
      rd_hit  = 1'b0;
      cmd_hit = 1'b0;
      clr_hit = 1'b0;
      case (base)
         BASE_INFRA:
         begin
            rd_hit = 1'b1;  // Cleared below for WO and holes
            case (offset)
               OFS_IMP_VERSION: rd_data = IMP_VERSION;
               OFS_BUILD_DATE:  rd_data = BUILD_DATE;
               OFS_STATUS:      rd_data = {60'd0, status};
               OFS_CAPABILITY:  rd_data = {OTHER_CAPABILITY, ENGINE_NUMBER, CARD_TYPE};
               OFS_NAME1:       rd_data = ACTION_NAME_STR1;
               OFS_NAME2:       rd_data = ACTION_NAME_STR2;
               OFS_NAME3:       rd_data = ACTION_NAME_STR3;
               OFS_NAME4:       rd_data = ACTION_NAME_STR4;
               OFS_COMMAND:
               begin
                  rd_hit  = 1'b0;  // Write only
                  cmd_hit = 1'b1;
               end
               default:         rd_hit = 1'b0;
            endcase
         end
         BASE_DEBUG:
         begin
            rd_hit = 1'b1;
            case (offset)
               OFS_AXI_CMD: rd_data = debug.axi_cnt_cmd;
               OFS_AXI_RSP: rd_data = debug.axi_cnt_rsp;
               OFS_BUF_CNT: rd_data = debug.buf_cnt;
               OFS_DBG_CLEAR:
               begin
                  rd_hit  = 1'b0;  // Write only
                  clr_hit = 1'b1;
               end
               default:     rd_hit = 1'b0;
            endcase
         end
         BASE_FIR:
         begin
            if (offset == OFS_FIR_BRIDGE)
            begin
               rd_hit  = 1'b1;
               rd_data = {60'd0, debug.fir};  // Flags zero extended
            end
         end
         default: ;  // Unmapped group
      endcase
   end

   // ==================================================
   // Response and self clearing write registers
   // ==================================================
   always_ff @(posedge clk or negedge resetn)
   begin
      if (!resetn)
      begin
         rsp_valid        <= 1'b0;
         rsp_error        <= 1'b0;
         command_pulse    <= 1'b0;
         debug_info_clear <= 1'b0;
      end
      else
      begin
         rsp_valid <= global_req.wr | global_req.rd;
         rsp_error <= (global_req.wr & ~(cmd_hit | clr_hit))  // RO or hole
                    | (global_req.rd & ~rd_hit);               // WO or hole
         command_pulse    <= global_req.wr & cmd_hit & global_req.din[0];
         debug_info_clear <= global_req.wr & clr_hit & global_req.din[0];
      end
   end

   always_ff @(posedge clk)
   begin
      if (global_req.rd)
         rsp_data <= rd_data;
   end

   assign global_rsp = '{valid: rsp_valid, error: rsp_error, data: rsp_data};

endmodule

/* rtl/action_bridge.sv */
module action_bridge
   import mmio_pkg::*;
(
   input  logic      clk,
   input  logic      resetn,
   input  mmio_req_t action_req,
   output mmio_rsp_t action_rsp,
   output logic      lcl_mmio_wr,
   output logic      lcl_mmio_rd,
   output lcl_data_t lcl_mmio_addr,
   output lcl_data_t lcl_mmio_din,
   input  logic      lcl_mmio_ack,
   input  logic      lcl_mmio_rsp,   // 1 good, 0 bad
   input  logic      lcl_mmio_dv,
   input  lcl_data_t lcl_mmio_dout
);

   logic lane_hi;  // Latched lane bit of the request

   // Strobes to action
   always_ff @(posedge clk or negedge resetn)
   begin
      if (!resetn)
      begin
         lcl_mmio_wr <= 1'b0;
         lcl_mmio_rd <= 1'b0;
      end
      else
      begin
         lcl_mmio_wr <= action_req.wr;
         lcl_mmio_rd <= action_req.rd;
      end
   end

   // Address, data and lane captured with the strobe
   always_ff @(posedge clk)
   begin
      if (action_req.wr || action_req.rd)
      begin
         lcl_mmio_addr <= {1'b0, action_req.addr[30:0]};  // Area bit dropped
         lcl_mmio_din  <= action_req.addr[LANE_BIT] ? action_req.din[63:32]
                                                    : action_req.din[31:0];
         lane_hi       <= action_req.addr[LANE_BIT];
      end
   end

   // Reply ends on ack or dv
   assign action_rsp.valid = lcl_mmio_ack | lcl_mmio_dv;
   assign action_rsp.error = ~lcl_mmio_rsp;
   assign action_rsp.data  = lane_hi ? {lcl_mmio_dout, 32'd0}
                                     : {32'd0, lcl_mmio_dout};

endmodule

/* rtl/debug_snapshot.sv */
module debug_snapshot
   import mmio_pkg::*;
(
   input  logic          clk,
   input  logic          resetn,
   input  bridge_debug_t debug_bus_data_bridge,
   output bridge_debug_t debug,
   output status_t       status
);

   // Counters sampled once
   always_ff @(posedge clk)
   begin
      debug <= debug_bus_data_bridge;
   end

   // Status straight from the raw bus
   always_ff @(posedge clk or negedge resetn)
   begin
      if (!resetn)
         status <= '0;
      else
      begin
         status.bridge_idle <= (debug_bus_data_bridge.buf_cnt == '0);  // Buffers empty
         status.axi_busy    <= (debug_bus_data_bridge.axi_cnt_cmd
                                != debug_bus_data_bridge.axi_cnt_rsp);  // Cmds unanswered
         status.fatal_error <= |debug_bus_data_bridge.fir;
         status.tlx_busy    <= 1'b0;
      end
   end

endmodule

/* rtl/soft_reset_timer.sv */
module soft_reset_timer
   import mmio_pkg::*;
(
   input  logic clk,
   input  logic resetn,
   input  logic command_pulse,
   output logic soft_reset_action
);

   localparam int CNT_W = $clog2(SOFT_RESET_CYCLES);

   logic [CNT_W-1:0] cnt;  // Cycles spent in reset

   always_ff @(posedge clk or negedge resetn)
   begin
      if (!resetn)
      begin
         soft_reset_action <= 1'b0;
         cnt               <= '0;
      end
      else if (command_pulse)
      begin
         soft_reset_action <= 1'b1;  // New command restarts the window
         cnt               <= '0;
      end
      else if (soft_reset_action)
      begin
         if (cnt == CNT_W'(SOFT_RESET_CYCLES - 1))
            soft_reset_action <= 1'b0;  // Last cycle done
         cnt <= cnt + 1'b1;
      end
   end

endmodule

/* rtl/mmio_top.sv */
module mmio_top
   import mmio_pkg::*;
#(
   parameter mmio_data_t  IMP_VERSION      = 64'h1000_0000_0000_0000,
   parameter mmio_data_t  BUILD_DATE       = 64'h0000_2000_0101_0800,
   parameter mmio_data_t  ACTION_NAME_STR1 = 64'h7465_7374_2020_2020,  // "test"
   parameter mmio_data_t  ACTION_NAME_STR2 = 64'h2020_2020_2020_2020,  // Spaces
   parameter mmio_data_t  ACTION_NAME_STR3 = 64'h2020_2020_2020_2020,
   parameter mmio_data_t  ACTION_NAME_STR4 = 64'h2020_2020_2020_2020,
   parameter logic [7:0]  ENGINE_NUMBER    = 8'h01,
   parameter logic [47:0] OTHER_CAPABILITY = 48'h0,
   parameter logic [7:0]  CARD_TYPE        = 8'h31
)
(
   input  logic          clk,
   input  logic          resetn,
   // Host side
   input  logic          mmio_wr,
   input  logic          mmio_rd,
   input  logic          mmio_dw,
   input  mmio_addr_t    mmio_addr,
   input  mmio_data_t    mmio_din,
   output mmio_data_t    mmio_dout,
   output logic          mmio_done,
   output logic          mmio_failed,
   // Action side
   output logic          lcl_mmio_wr,
   output logic          lcl_mmio_rd,
   output lcl_data_t     lcl_mmio_addr,
   output lcl_data_t     lcl_mmio_din,
   input  logic          lcl_mmio_ack,
   input  logic          lcl_mmio_rsp,
   input  lcl_data_t     lcl_mmio_dout,
   input  logic          lcl_mmio_dv,
   // Debug and control
   input  bridge_debug_t debug_bus_data_bridge,
   output logic          debug_info_clear,
   output logic          soft_reset_action
);

   mmio_req_t     global_req;
   mmio_req_t     action_req;
   mmio_rsp_t     global_rsp;
   mmio_rsp_t     action_rsp;
   bridge_debug_t debug;
   status_t       status;
   logic          command_pulse;

   // ==================================================
   // Host port
   // ==================================================
   mmio_host_port u_host_port (
      .clk         (clk),
      .resetn      (resetn),
      .mmio_wr     (mmio_wr),
      .mmio_rd     (mmio_rd),
      .mmio_dw     (mmio_dw),
      .mmio_addr   (mmio_addr),
      .mmio_din    (mmio_din),
      .mmio_dout   (mmio_dout),
      .mmio_done   (mmio_done),
      .mmio_failed (mmio_failed),
      .global_req  (global_req),
      .action_req  (action_req),
      .global_rsp  (global_rsp),
      .action_rsp  (action_rsp)
   );

   // Infrastructure registers
   global_reg_file #(
      .IMP_VERSION      (IMP_VERSION),
      .BUILD_DATE       (BUILD_DATE),
      .ACTION_NAME_STR1 (ACTION_NAME_STR1),
      .ACTION_NAME_STR2 (ACTION_NAME_STR2),
      .ACTION_NAME_STR3 (ACTION_NAME_STR3),
      .ACTION_NAME_STR4 (ACTION_NAME_STR4),
      .ENGINE_NUMBER    (ENGINE_NUMBER),
      .OTHER_CAPABILITY (OTHER_CAPABILITY),
      .CARD_TYPE        (CARD_TYPE)
   ) u_global_reg_file (
      .clk              (clk),
      .resetn           (resetn),
      .global_req       (global_req),
      .debug            (debug),
      .status           (status),
      .global_rsp       (global_rsp),
      .command_pulse    (command_pulse),
      .debug_info_clear (debug_info_clear)
   );

   // Action registers
   action_bridge u_action_bridge (
      .clk           (clk),
      .resetn        (resetn),
      .action_req    (action_req),
      .action_rsp    (action_rsp),
      .lcl_mmio_wr   (lcl_mmio_wr),
      .lcl_mmio_rd   (lcl_mmio_rd),
      .lcl_mmio_addr (lcl_mmio_addr),
      .lcl_mmio_din  (lcl_mmio_din),
      .lcl_mmio_ack  (lcl_mmio_ack),
      .lcl_mmio_rsp  (lcl_mmio_rsp),
      .lcl_mmio_dv   (lcl_mmio_dv),
      .lcl_mmio_dout (lcl_mmio_dout)
   );

   debug_snapshot u_debug_snapshot (
      .clk                   (clk),
      .resetn                (resetn),
      .debug_bus_data_bridge (debug_bus_data_bridge),
      .debug                 (debug),
      .status                (status)
   );

   soft_reset_timer u_soft_reset_timer (
      .clk               (clk),
      .resetn            (resetn),
      .command_pulse     (command_pulse),
      .soft_reset_action (soft_reset_action)
   );

endmodule

/* bench/tb_mmio.sv */
module tb_mmio
   import mmio_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   // ==================================================
   // Run length and identity values
   // ==================================================
   localparam int RESET_CYCLES = 8;
   localparam int N_DBG        = 4;   // Debug bus rounds
   localparam int N_GLOBAL     = 40;  // Random global accesses
   localparam int N_ACTION     = 40;  // Random action accesses
   localparam int N_TRANS      = 7 + 5 * N_DBG + 5 + 2 + N_GLOBAL + N_ACTION;
   localparam int WAIT_LIMIT   = 20;  // Cycles until done or failed

   localparam mmio_data_t  TB_IMP_VERSION = 64'h0123_4567_89AB_CDEF;
   localparam mmio_data_t  TB_BUILD_DATE  = 64'h0000_1357_9BDF_0246;
   localparam mmio_data_t  TB_NAME1       = 64'h6D6D_696F_5F74_6231;
   localparam mmio_data_t  TB_NAME2       = 64'h6163_6365_6C5F_3232;
   localparam mmio_data_t  TB_NAME3       = 64'h5151_3333_7777_9999;
   localparam mmio_data_t  TB_NAME4       = 64'hFEDC_BA98_7654_3210;
   localparam logic [7:0]  TB_ENGINE      = 8'h5A;
   localparam logic [47:0] TB_OTHER_CAP   = 48'hA5A5_0F0F_3C3C;
   localparam logic [7:0]  TB_CARD_TYPE   = 8'hC3;

   logic          clk;
   logic          resetn;
   logic          mmio_wr;
   logic          mmio_rd;
   logic          mmio_dw;
   mmio_addr_t    mmio_addr;
   mmio_data_t    mmio_din;
   mmio_data_t    mmio_dout;
   logic          mmio_done;
   logic          mmio_failed;
   logic          lcl_mmio_wr;
   logic          lcl_mmio_rd;
   lcl_data_t     lcl_mmio_addr;
   lcl_data_t     lcl_mmio_din;
   logic          lcl_mmio_ack;
   logic          lcl_mmio_rsp;
   lcl_data_t     lcl_mmio_dout;
   logic          lcl_mmio_dv;
   bridge_debug_t dbg_bus;
   logic          debug_info_clear;
   logic          soft_reset_action;

   int            act_latency;  // Reply delay of the next action access
   logic          act_good;     // Reply rsp of the next action access
   lcl_data_t     act_rdata;
   mmio_data_t    dout_held;    // Data of the last good read
   logic [31:0]   lcg_state = 32'd58;

   mmio_top #(
      .IMP_VERSION      (TB_IMP_VERSION),
      .BUILD_DATE       (TB_BUILD_DATE),
      .ACTION_NAME_STR1 (TB_NAME1),
      .ACTION_NAME_STR2 (TB_NAME2),
      .ACTION_NAME_STR3 (TB_NAME3),
      .ACTION_NAME_STR4 (TB_NAME4),
      .ENGINE_NUMBER    (TB_ENGINE),
      .OTHER_CAPABILITY (TB_OTHER_CAP),
      .CARD_TYPE        (TB_CARD_TYPE)
   ) uut (
      .clk                   (clk),
      .resetn                (resetn),
      .mmio_wr               (mmio_wr),
      .mmio_rd               (mmio_rd),
      .mmio_dw               (mmio_dw),
      .mmio_addr             (mmio_addr),
      .mmio_din              (mmio_din),
      .mmio_dout             (mmio_dout),
      .mmio_done             (mmio_done),
      .mmio_failed           (mmio_failed),
      .lcl_mmio_wr           (lcl_mmio_wr),
      .lcl_mmio_rd           (lcl_mmio_rd),
      .lcl_mmio_addr         (lcl_mmio_addr),
      .lcl_mmio_din          (lcl_mmio_din),
      .lcl_mmio_ack          (lcl_mmio_ack),
      .lcl_mmio_rsp          (lcl_mmio_rsp),
      .lcl_mmio_dout         (lcl_mmio_dout),
      .lcl_mmio_dv           (lcl_mmio_dv),
      .debug_bus_data_bridge (dbg_bus),
      .debug_info_clear      (debug_info_clear),
      .soft_reset_action     (soft_reset_action)
   );

   // ==================================================
   // Random numbers, error handling, checks
   // ==================================================
   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return {lcg_state[15:0], lcg_state[31:16]};  // Better bits low
   endfunction

   function automatic mmio_data_t rand64();
      logic [31:0] hi;
      hi = lcg_next();
      return {hi, lcg_next()};
   endfunction

   task automatic report_error(string why);
      $display("%s", why);
      $display("test failed");
      $fatal(1);
   endtask

   task automatic check_data(string name, mmio_data_t got, mmio_data_t exp);
      if (got !== exp)
         report_error($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
   endtask

   task automatic check_flag(string name, logic got, logic exp);
      if (got !== exp)
         report_error($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
   endtask

   task automatic check_lcl(string name, lcl_data_t got, lcl_data_t exp);
      if (got !== exp)
         report_error($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
   endtask

   function automatic mmio_addr_t gaddr(area_base_t base, area_offset_t ofs);
      return {10'd0, base, ofs};
   endfunction

   // Expected global response, straight from the register map
   function automatic void model_global(input mmio_addr_t addr, input logic is_wr,
                                        output logic exp_fail, output mmio_data_t exp_data);
      logic    readable;
      logic    writable;
      status_t st;
      readable       = 1'b1;
      writable       = 1'b0;
      exp_data       = '0;
      st.fatal_error = (dbg_bus.fir != '0);
      st.axi_busy    = (dbg_bus.axi_cnt_cmd != dbg_bus.axi_cnt_rsp);
      st.tlx_busy    = 1'b0;
      st.bridge_idle = (dbg_bus.buf_cnt == '0);
      case ({addr[21:8], addr[7:0]})
         {BASE_INFRA, OFS_IMP_VERSION}: exp_data = TB_IMP_VERSION;
         {BASE_INFRA, OFS_BUILD_DATE}:  exp_data = TB_BUILD_DATE;
         {BASE_INFRA, OFS_STATUS}:      exp_data = {60'd0, st};
         {BASE_INFRA, OFS_CAPABILITY}:  exp_data = {TB_OTHER_CAP, TB_ENGINE, TB_CARD_TYPE};
         {BASE_INFRA, OFS_NAME1}:       exp_data = TB_NAME1;
         {BASE_INFRA, OFS_NAME2}:       exp_data = TB_NAME2;
         {BASE_INFRA, OFS_NAME3}:       exp_data = TB_NAME3;
         {BASE_INFRA, OFS_NAME4}:       exp_data = TB_NAME4;
         {BASE_DEBUG, OFS_AXI_CMD}:     exp_data = dbg_bus.axi_cnt_cmd;
         {BASE_DEBUG, OFS_AXI_RSP}:     exp_data = dbg_bus.axi_cnt_rsp;
         {BASE_DEBUG, OFS_BUF_CNT}:     exp_data = dbg_bus.buf_cnt;
         {BASE_FIR, OFS_FIR_BRIDGE}:    exp_data = {60'd0, dbg_bus.fir};
         {BASE_INFRA, OFS_COMMAND}, {BASE_DEBUG, OFS_DBG_CLEAR}:
         begin
            readable = 1'b0;  // The two write only registers
            writable = 1'b1;
         end
         default: readable = 1'b0;
      endcase
      exp_fail = is_wr ? !writable : !readable;
   endfunction

   // ==================================================
   // Host side tasks, all entered on a falling edge
   // ==================================================
   task automatic drive_request(logic is_wr, logic dw, mmio_addr_t addr, mmio_data_t din);
      mmio_wr   = is_wr;
      mmio_rd   = !is_wr;
      mmio_dw   = dw;
      mmio_addr = addr;
      mmio_din  = din;
   endtask

   task automatic release_request();
      @(negedge clk);
      mmio_wr = 1'b0;  // Single cycle strobe
      mmio_rd = 1'b0;
   endtask

   task automatic wait_completion(output int cycles);
      cycles = 0;
      while (!(mmio_done || mmio_failed))
      begin
         @(negedge clk);
         cycles++;
         if (cycles > WAIT_LIMIT)
            report_error("No done or failed from the DUT after a request");
      end
   endtask

   task automatic global_access(logic is_wr, mmio_addr_t addr, mmio_data_t din);
      logic       exp_fail;
      mmio_data_t exp_data;
      int         cycles;
      model_global(addr, is_wr, exp_fail, exp_data);
      drive_request(is_wr, 1'b1, addr, din);
      release_request();
      wait_completion(cycles);
      if (cycles != 1)
         report_error("Global access completed at the wrong cycle");
      check_flag("mmio_done", mmio_done, !exp_fail);
      check_flag("mmio_failed", mmio_failed, exp_fail);
      if (!is_wr && !exp_fail)
         dout_held = exp_data;
      check_data("mmio_dout", mmio_dout, dout_held);  // Old data kept otherwise
   endtask

   task automatic width_mismatch(mmio_addr_t addr, logic is_wr);
      drive_request(is_wr, addr[ACTION_ACCESS_BIT], addr, rand64());  // Wrong dw per area
      release_request();
      check_flag("mmio_failed", mmio_failed, 1'b1);
      check_flag("mmio_done", mmio_done, 1'b0);
      check_flag("lcl_mmio_wr", lcl_mmio_wr, 1'b0);  // Never forwarded
      check_flag("lcl_mmio_rd", lcl_mmio_rd, 1'b0);
      repeat (3)
      begin
         @(negedge clk);
         check_flag("mmio_done", mmio_done, 1'b0);
         check_flag("mmio_failed", mmio_failed, 1'b0);
      end
      check_data("mmio_dout", mmio_dout, dout_held);
   endtask

   task automatic action_access(logic is_wr, mmio_addr_t addr, mmio_data_t din);
      logic [31:0] r;
      int          cycles;
      mmio_data_t  exp_dout;
      r           = lcg_next();
      act_latency = 1 + int'(r[2:0]) % 6;
      act_good    = (r[5:4] != 2'b00);  // One in four answers bad
      act_rdata   = lcg_next();
      exp_dout    = addr[LANE_BIT] ? {act_rdata, 32'd0} : {32'd0, act_rdata};
      drive_request(is_wr, 1'b0, addr, din);
      release_request();
      check_flag("lcl_mmio_wr", lcl_mmio_wr, is_wr);
      check_flag("lcl_mmio_rd", lcl_mmio_rd, !is_wr);
      check_lcl("lcl_mmio_addr", lcl_mmio_addr, {1'b0, addr[30:0]});
      check_lcl("lcl_mmio_din", lcl_mmio_din, addr[LANE_BIT] ? din[63:32] : din[31:0]);
      wait_completion(cycles);
      if (cycles != act_latency + 1)
         report_error("Action access did not complete one cycle after the reply");
      check_flag("mmio_done", mmio_done, act_good);
      check_flag("mmio_failed", mmio_failed, !act_good);
      if (!is_wr && act_good)
         dout_held = exp_dout;
      check_data("mmio_dout", mmio_dout, dout_held);
   endtask

   // ==================================================
   // Clock, watchdog, action responder
   // ==================================================
   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   initial
   begin
      repeat (RESET_CYCLES + 200 * N_TRANS) @(posedge clk);
      report_error("Watchdog expired before the tests finished");
   end

   initial
   begin
      logic reply_rd;
      lcl_mmio_ack  = 1'b0;
      lcl_mmio_dv   = 1'b0;
      lcl_mmio_rsp  = 1'b1;
      lcl_mmio_dout = '0;
      forever
      begin
         @(negedge clk);
         if (lcl_mmio_wr || lcl_mmio_rd)
         begin
            reply_rd = lcl_mmio_rd;
            repeat (act_latency) @(negedge clk);
            lcl_mmio_ack  = ~reply_rd;  // Writes acked, reads answer with dv
            lcl_mmio_dv   = reply_rd;
            lcl_mmio_rsp  = act_good;
            lcl_mmio_dout = act_rdata;
            @(negedge clk);
            lcl_mmio_ack  = 1'b0;
            lcl_mmio_dv   = 1'b0;
         end
      end
   end

   // ==================================================
   // Test sequence
   // ==================================================
   initial
   begin
      logic [31:0] r;
      area_base_t  base;
      mmio_addr_t  act_addr;
      resetn      = 1'b0;
      mmio_wr     = 1'b0;
      mmio_rd     = 1'b0;
      mmio_dw     = 1'b0;
      mmio_addr   = '0;
      mmio_din    = '0;
      dbg_bus     = '0;
      act_latency = 1;
      act_good    = 1'b1;
      act_rdata   = '0;
      dout_held   = '0;
      repeat (RESET_CYCLES) @(negedge clk);
      resetn = 1'b1;
      @(negedge clk);
      check_flag("mmio_done", mmio_done, 1'b0);  // Idle after reset
      check_flag("mmio_failed", mmio_failed, 1'b0);
      check_flag("lcl_mmio_wr", lcl_mmio_wr, 1'b0);
      check_flag("lcl_mmio_rd", lcl_mmio_rd, 1'b0);
      check_flag("soft_reset_action", soft_reset_action, 1'b0);
      check_flag("debug_info_clear", debug_info_clear, 1'b0);
      check_data("mmio_dout", mmio_dout, '0);

      // Identity registers
      global_access(1'b0, gaddr(BASE_INFRA, OFS_IMP_VERSION), '0);
      global_access(1'b0, gaddr(BASE_INFRA, OFS_BUILD_DATE), '0);
      global_access(1'b0, gaddr(BASE_INFRA, OFS_NAME1), '0);
      global_access(1'b0, gaddr(BASE_INFRA, OFS_NAME2), '0);
      global_access(1'b0, gaddr(BASE_INFRA, OFS_NAME3), '0);
      global_access(1'b0, gaddr(BASE_INFRA, OFS_NAME4), '0);
      global_access(1'b0, gaddr(BASE_INFRA, OFS_CAPABILITY), '0);

      // Debug bus values with idle, equal counters and no faults mixed in
      for (int i = 0; i < N_DBG; i++)
      begin
         r                   = lcg_next();
         dbg_bus.axi_cnt_cmd = rand64();
         dbg_bus.axi_cnt_rsp = r[0] ? dbg_bus.axi_cnt_cmd : rand64();
         dbg_bus.buf_cnt     = r[1] ? '0 : rand64();
         dbg_bus.fir         = r[2] ? '0 : r[7:4];
         repeat (4) @(negedge clk);  // Let snapshot settle
         global_access(1'b0, gaddr(BASE_DEBUG, OFS_AXI_CMD), '0);
         global_access(1'b0, gaddr(BASE_DEBUG, OFS_AXI_RSP), '0);
         global_access(1'b0, gaddr(BASE_DEBUG, OFS_BUF_CNT), '0);
         global_access(1'b0, gaddr(BASE_FIR, OFS_FIR_BRIDGE), '0);
         global_access(1'b0, gaddr(BASE_INFRA, OFS_STATUS), '0);
      end

      // Failing accesses
      global_access(1'b0, gaddr(BASE_INFRA, 8'h20), '0);
      global_access(1'b1, gaddr(BASE_INFRA, OFS_IMP_VERSION), rand64());
      global_access(1'b0, gaddr(BASE_INFRA, OFS_COMMAND), '0);
      width_mismatch(gaddr(BASE_DEBUG, OFS_AXI_CMD), 1'b0);
      r = lcg_next();
      width_mismatch({1'b1, r[30:0]}, 1'b1);

      // Soft reset window
      check_flag("soft_reset_action", soft_reset_action, 1'b0);
      global_access(1'b1, gaddr(BASE_INFRA, OFS_COMMAND), 64'h1);
      repeat (SOFT_RESET_CYCLES)
      begin
         check_flag("soft_reset_action", soft_reset_action, 1'b1);
         @(negedge clk);
      end
      check_flag("soft_reset_action", soft_reset_action, 1'b0);

      // Debug clear pulses once
      drive_request(1'b1, 1'b1, gaddr(BASE_DEBUG, OFS_DBG_CLEAR), 64'h1);
      release_request();
      check_flag("debug_info_clear", debug_info_clear, 1'b1);
      @(negedge clk);
      check_flag("debug_info_clear", debug_info_clear, 1'b0);
      check_flag("mmio_done", mmio_done, 1'b1);

      // Random global traffic
      for (int i = 0; i < N_GLOBAL; i++)
      begin
         r = lcg_next();
         case (r[9:8])
            2'd0:    base = BASE_INFRA;
            2'd1:    base = BASE_DEBUG;
            2'd2:    base = BASE_FIR;
            default: base = area_base_t'(lcg_next());
         endcase
         global_access(r[12], {1'b0, r[31:23], base, {1'b0, r[6:3], 3'b000}}, rand64());
      end

      // Random action traffic
      for (int i = 0; i < N_ACTION; i++)
      begin
         r        = lcg_next();
         act_addr = lcg_next();
         act_addr[ACTION_ACCESS_BIT] = 1'b1;  // Action area, lane bit stays random
         action_access(r[20], act_addr, rand64());
      end

      $display("test passed");
      $finish;
   end

endmodule

/* mmio.f */
rtl/mmio_pkg.sv
rtl/mmio_host_port.sv
rtl/global_reg_file.sv
rtl/action_bridge.sv
rtl/debug_snapshot.sv
rtl/soft_reset_timer.sv
rtl/mmio_top.sv
bench/tb_mmio.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the MMIO testbench, exit status is the simulator's
set -e
cd "$(dirname "$0")"
verilator --binary --timing --timescale 1ns/1ps -f mmio.f --top-module tb_mmio -o tb_mmio
./obj_dir/tb_mmio
